/* design/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // Width of the device offset field of a host address
  localparam int dev_addr_width = 20;

  ////////////////////
  // Device address map
  ////////////////////
  localparam logic [dev_addr_width-1:0] req_fifo_addr        = 20'h0_0100;
  localparam logic [dev_addr_width-1:0] req_credits_addr     = 20'h0_0200;
  localparam logic [dev_addr_width-1:0] resp_fifo_addr       = 20'h0_0300;
  localparam logic [dev_addr_width-1:0] resp_entries_addr    = 20'h0_0400;
  localparam logic [dev_addr_width-1:0] net_req_fifo_addr    = 20'h0_0500;
  localparam logic [dev_addr_width-1:0] net_req_entries_addr = 20'h0_0600;

  ////////////////////
  // Host packet framing
  ////////////////////

  // 32-bit host words in one packet, word 0 goes first
  localparam int host_word_width = 32;
  localparam int host_words      = 4;

endpackage

`default_nettype wire

/* design/net_pkg.sv */
`default_nettype none

package net_pkg;

  localparam int cord_width   = 8;
  localparam int data_width   = 32;
  localparam int addr_width   = 32;
  localparam int reg_id_width = 8;
  // One mask bit per byte of data
  localparam int mask_width   = data_width / 8;

  typedef enum logic [7:0]
  {
    remote_load  = 8'd0,
    remote_store = 8'd1,
    response     = 8'd2
  } net_op_e;

  // Request view, x_dst sits at bit 0
  typedef struct packed
  {
    logic [15:0]             reserved;
    logic [addr_width-1:0]   addr;
    net_op_e                 op;
    logic [reg_id_width-1:0] reg_id;
    logic [data_width-1:0]   payload;
    logic [cord_width-1:0]   y_src;
    logic [cord_width-1:0]   x_src;
    logic [cord_width-1:0]   y_dst;
    logic [cord_width-1:0]   x_dst;
  } host_req_s;

  // Response view of the same 128 bits
  typedef struct packed
  {
    logic [55:0]             reserved;
    net_op_e                 op;
    logic [data_width-1:0]   payload;
    logic [7:0]              reserved_lo;
    logic [reg_id_width-1:0] reg_id;
    logic [cord_width-1:0]   y_dst;
    logic [cord_width-1:0]   x_dst;
  } host_rsp_s;

  typedef union packed
  {
    host_req_s req;
    host_rsp_s rsp;
  } host_packet_u;

endpackage

`default_nettype wire

/* design/two_slot_fifo.sv */
`default_nettype none

module two_slot_fifo
  #(parameter int width_p = 32)
  (input  logic               clk_i
   , input  logic               reset_i
   , input  logic [width_p-1:0] data_i
   , input  logic               v_i
   , output logic               ready_o
   , output logic [width_p-1:0] data_o
   , output logic               v_o
   , input  logic               yumi_i
   );

  logic [width_p-1:0] mem_r [0:1];
  logic               wptr_r;
  logic               rptr_r;
  logic [1:0]         count_r;
  logic               push;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rptr_r];
  assign push    = v_i & ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end
    else
    begin
      if (push)
        wptr_r <= ~wptr_r;
      if (yumi_i)
        rptr_r <= ~rptr_r;
      case ({push, yumi_i})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i)
    if (push)
      mem_r[wptr_r] <= data_i;

  // Consumer must only pop a present entry
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);
  a_count_range: assert property (@(posedge clk_i) disable iff (reset_i) count_r != 2'd3);

endmodule

`default_nettype wire

/* design/word_sipo.sv */
`default_nettype none

module word_sipo
  #(parameter int fill_width_p = 32)
  (input  logic                    clk_i
   , input  logic                    reset_i
   , input  logic [fill_width_p-1:0] data_i
   , input  logic                    v_i
   , output logic                    ready_o
   , output net_pkg::host_packet_u   packet_o
   , output logic                    v_o
   , input  logic                    yumi_i
   );

  localparam int els_lp   = bridge_pkg::host_words * bridge_pkg::host_word_width / fill_width_p;
  localparam int count_lp = $clog2(els_lp + 1);

  logic [els_lp-1:0][fill_width_p-1:0] words_r;
  logic [count_lp-1:0]                 count_r;

  assign v_o      = (count_r == count_lp'(els_lp));
  assign ready_o  = ~v_o;
  assign packet_o = words_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (yumi_i)
      count_r <= '0;
    else if (v_i & ready_o)
      count_r <= count_r + 1'b1;
  end

  // Word k lands at bits 32k and up
  always_ff @(posedge clk_i)
    if (v_i & ready_o)
      words_r[count_r] <= data_i;

endmodule

`default_nettype wire

/* design/word_piso.sv */
`default_nettype none

module word_piso
  #(parameter int fill_width_p = 32)
  (input  logic                    clk_i
   , input  logic                    reset_i
   , input  net_pkg::host_packet_u   packet_i
   , input  logic                    v_i
   , output logic                    ready_o
   , output logic [fill_width_p-1:0] data_o
   , output logic                    v_o
   , input  logic                    yumi_i
   );

  localparam int els_lp = bridge_pkg::host_words * bridge_pkg::host_word_width / fill_width_p;
  localparam int idx_lp = (els_lp > 1) ? $clog2(els_lp) : 1;

  logic [els_lp-1:0][fill_width_p-1:0] words_r;
  logic [idx_lp-1:0]                   idx_r;
  logic                                v_r;

  assign ready_o = ~v_r;
  assign v_o     = v_r;
  assign data_o  = words_r[idx_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_r   <= 1'b0;
      idx_r <= '0;
    end
    else if (v_i & ready_o)
    begin
      v_r   <= 1'b1;
      idx_r <= '0;
    end
    else if (yumi_i)
    begin
      // Empty again once the last word is taken
      if (idx_r == idx_lp'(els_lp - 1))
        v_r <= 1'b0;
      idx_r <= idx_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
    if (v_i & ready_o)
      words_r <= packet_i;

endmodule

`default_nettype wire

/* design/net_endpoint.sv */
`default_nettype none

module net_endpoint
  #(parameter int credits_p = 8
    , localparam int credit_width_lp = $clog2(credits_p + 1)
    )
  (input  logic                                clk_i
   , input  logic                                reset_i

   , input  logic                                send_v_i
   , input  net_pkg::host_packet_u               send_packet_i
   , output logic                                send_ready_o
   , output logic [credit_width_lp-1:0]          credits_used_o

   , output logic                                net_out_v_o
   , output net_pkg::host_packet_u               net_out_packet_o
   , input  logic                                net_credit_i

   , input  logic                                net_rsp_v_i
   , input  logic [net_pkg::data_width-1:0]      net_rsp_data_i
   , input  logic [net_pkg::reg_id_width-1:0]    net_rsp_reg_id_i
   , input  logic [7:0]                          net_rsp_op_i

   , output logic                                rsp_v_o
   , output logic [net_pkg::data_width-1:0]      rsp_data_o
   , output logic [net_pkg::reg_id_width-1:0]    rsp_reg_id_o
   , output logic [7:0]                          rsp_op_o
   , input  logic                                rsp_yumi_i

   , input  logic                                net_in_v_i
   , output logic                                net_in_ready_o
   , output logic                                net_in_ack_o
   , input  logic                                req_ready_i
   );

  logic [credit_width_lp-1:0] credits_used_r;

  ////////////////////
  // Outgoing credits
  ////////////////////
  assign send_ready_o     = (credits_used_r < credit_width_lp'(credits_p));
  assign credits_used_o   = credits_used_r;
  assign net_out_v_o      = send_v_i;
  assign net_out_packet_o = send_packet_i;

  // Send and return in one cycle cancel out
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credits_used_r <= '0;
    else if (send_v_i & ~net_credit_i)
      credits_used_r <= credits_used_r + 1'b1;
    else if (net_credit_i & ~send_v_i)
      credits_used_r <= credits_used_r - 1'b1;
  end

  ////////////////////
  // Response holding register
  ////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rsp_v_o <= 1'b0;
    else if (net_rsp_v_i)
      rsp_v_o <= 1'b1;
    else if (rsp_yumi_i)
      rsp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
    if (net_rsp_v_i)
    begin
      rsp_data_o   <= net_rsp_data_i;
      rsp_reg_id_o <= net_rsp_reg_id_i;
      rsp_op_o     <= net_rsp_op_i;
    end

  ////////////////////
  // Incoming request ack
  ////////////////////
  assign net_in_ready_o = req_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      net_in_ack_o <= 1'b0;
    else
      net_in_ack_o <= net_in_v_i & req_ready_i;
  end

  // Bridge may only send with a free credit
  a_send_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    send_v_i |-> send_ready_o);
  a_credit_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    net_credit_i && !send_v_i |-> credits_used_r != '0);
  // Network must wait until the held response is drained
  a_rsp_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
    net_rsp_v_i |-> !rsp_v_o);

endmodule

`default_nettype wire

/* design/mmio_fifo_bridge.sv */
`default_nettype none

module mmio_fifo_bridge
  #(parameter int fill_width_p = 32
    , parameter int credits_p = 8
    , localparam int credit_width_lp = $clog2(credits_p + 1)
    )
  (input  logic                                    clk_i
   , input  logic                                    reset_i
   , input  logic [net_pkg::cord_width-1:0]          global_x_i
   , input  logic [net_pkg::cord_width-1:0]          global_y_i

   , input  logic [bridge_pkg::dev_addr_width-1:0]   fifo_addr_i
   , input  logic [fill_width_p-1:0]                 fifo_data_i
   , input  logic                                    fifo_v_i
   , output logic                                    fifo_yumi_o

   , output logic [fill_width_p-1:0]                 rev_data_o
   , output logic                                    rev_v_o
   , input  logic                                    rev_ready_i

   , output logic                                    send_v_o
   , output net_pkg::host_packet_u                   send_packet_o
   , input  logic                                    send_ready_i
   , input  logic [credit_width_lp-1:0]              credits_used_i

   , input  logic                                    rsp_v_i
   , input  logic [net_pkg::data_width-1:0]          rsp_data_i
   , input  logic [net_pkg::reg_id_width-1:0]        rsp_reg_id_i
   , input  logic [7:0]                              rsp_op_i
   , output logic                                    rsp_yumi_o

   , input  logic                                    net_in_v_i
   , input  logic [net_pkg::addr_width-1:0]          net_in_addr_i
   , input  logic [net_pkg::data_width-1:0]          net_in_data_i
   , input  logic [net_pkg::mask_width-1:0]          net_in_mask_i
   , input  logic                                    net_in_we_i
   , input  logic [net_pkg::cord_width-1:0]          net_in_src_x_i
   , input  logic [net_pkg::cord_width-1:0]          net_in_src_y_i
   , output logic                                    req_ready_o
   );

  net_pkg::host_packet_u   sipo_packet, rsp_packet, req_packet;
  logic                    sipo_v, sipo_ready, sipo_full, sipo_yumi;
  logic [fill_width_p-1:0] rsp_word, req_word;
  logic                    rsp_word_v, rsp_word_yumi, rsp_piso_ready;
  logic                    req_word_v, req_word_yumi;
  logic [fill_width_p-1:0] live_data, hold_data_r;
  logic                    live_v, hold_v_r;

  ////////////////////
  // Host to network
  ////////////////////
  word_sipo #(.fill_width_p(fill_width_p)) req_sipo
    (.clk_i(clk_i), .reset_i(reset_i)
     , .data_i(fifo_data_i), .v_i(sipo_v), .ready_o(sipo_ready)
     , .packet_o(sipo_packet), .v_o(sipo_full), .yumi_i(sipo_yumi)
     );

  // Full packet leaves as soon as a credit is free
  assign send_v_o      = sipo_full & send_ready_i;
  assign sipo_yumi     = send_v_o;
  assign send_packet_o = sipo_packet;

  ////////////////////
  // Network responses
  ////////////////////
  always_comb
  begin
    rsp_packet             = '0;
    rsp_packet.rsp.x_dst   = global_x_i;
    rsp_packet.rsp.y_dst   = global_y_i;
    rsp_packet.rsp.reg_id  = rsp_reg_id_i;
    rsp_packet.rsp.payload = rsp_data_i;
    rsp_packet.rsp.op      = net_pkg::response;
  end

  word_piso #(.fill_width_p(fill_width_p)) rsp_piso
    (.clk_i(clk_i), .reset_i(reset_i)
     , .packet_i(rsp_packet), .v_i(rsp_v_i), .ready_o(rsp_piso_ready)
     , .data_o(rsp_word), .v_o(rsp_word_v), .yumi_i(rsp_word_yumi)
     );

  assign rsp_yumi_o = rsp_v_i & rsp_piso_ready;

  ////////////////////
  // Network requests
  ////////////////////
  always_comb
  begin
    req_packet             = '0;
    req_packet.req.x_dst   = global_x_i;
    req_packet.req.y_dst   = global_y_i;
    req_packet.req.x_src   = net_in_src_x_i;
    req_packet.req.y_src   = net_in_src_y_i;
    req_packet.req.payload = net_in_data_i;
    req_packet.req.addr    = net_in_addr_i;
    // Byte mask rides in the reg_id field
    req_packet.req.reg_id[net_pkg::mask_width-1:0] = net_in_mask_i;
    if (net_in_we_i)
      req_packet.req.op = net_pkg::remote_store;
    else
      req_packet.req.op = net_pkg::remote_load;
  end

  word_piso #(.fill_width_p(fill_width_p)) req_piso
    (.clk_i(clk_i), .reset_i(reset_i)
     , .packet_i(req_packet), .v_i(net_in_v_i), .ready_o(req_ready_o)
     , .data_o(req_word), .v_o(req_word_v), .yumi_i(req_word_yumi)
     );

  ////////////////////
  // Host reply steering
  ////////////////////
  always_comb
  begin
    live_v    = fifo_v_i;
    live_data = '0;
    case (fifo_addr_i)
      bridge_pkg::req_fifo_addr:
        live_v = fifo_v_i & sipo_ready;
      bridge_pkg::req_credits_addr:
        live_data[credit_width_lp-1:0] = credits_used_i;
      bridge_pkg::resp_fifo_addr:
      begin
        live_v    = fifo_v_i & rsp_word_v;
        live_data = rsp_word;
      end
      bridge_pkg::resp_entries_addr:
        live_data[0] = rsp_word_v;
      bridge_pkg::net_req_fifo_addr:
      begin
        live_v    = fifo_v_i & req_word_v;
        live_data = req_word;
      end
      bridge_pkg::net_req_entries_addr:
        live_data[0] = req_word_v;
      // Unmapped addresses answer zero at once
      default:
        live_data = '0;
    endcase
  end

  // Reply is frozen while the host stalls
  assign rev_v_o     = hold_v_r | live_v;
  assign rev_data_o  = hold_v_r ? hold_data_r : live_data;
  assign fifo_yumi_o = rev_v_o & rev_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      hold_v_r <= 1'b0;
    else if (fifo_yumi_o)
      hold_v_r <= 1'b0;
    else if (live_v)
      hold_v_r <= 1'b1;
  end

  always_ff @(posedge clk_i)
    if (live_v & ~hold_v_r)
      hold_data_r <= live_data;

  // Side effects happen only when the reply retires
  assign sipo_v        = fifo_yumi_o & (fifo_addr_i == bridge_pkg::req_fifo_addr);
  assign rsp_word_yumi = fifo_yumi_o & (fifo_addr_i == bridge_pkg::resp_fifo_addr);
  assign req_word_yumi = fifo_yumi_o & (fifo_addr_i == bridge_pkg::net_req_fifo_addr);

endmodule

`default_nettype wire

/* design/host_net_top.sv */
`default_nettype none

module host_net_top
  #(parameter int fill_width_p = 32
    , parameter int credits_p = 8
    )
  (input  logic                                    clk_i
   , input  logic                                    reset_i
   , input  logic [net_pkg::cord_width-1:0]          global_x_i
   , input  logic [net_pkg::cord_width-1:0]          global_y_i

   , input  logic [bridge_pkg::dev_addr_width-1:0]   fwd_addr_i
   , input  logic [fill_width_p-1:0]                 fwd_data_i
   , input  logic                                    fwd_v_i
   , output logic                                    fwd_ready_o

   , output logic [fill_width_p-1:0]                 rev_data_o
   , output logic                                    rev_v_o
   , input  logic                                    rev_ready_i

   , output logic                                    net_out_v_o
   , output net_pkg::host_packet_u                   net_out_packet_o
   , input  logic                                    net_credit_i

   , input  logic                                    net_rsp_v_i
   , input  logic [net_pkg::data_width-1:0]          net_rsp_data_i
   , input  logic [net_pkg::reg_id_width-1:0]        net_rsp_reg_id_i
   , input  logic [7:0]                              net_rsp_op_i

   , input  logic                                    net_in_v_i
   , input  logic [net_pkg::addr_width-1:0]          net_in_addr_i
   , input  logic [net_pkg::data_width-1:0]          net_in_data_i
   , input  logic [net_pkg::mask_width-1:0]          net_in_mask_i
   , input  logic                                    net_in_we_i
   , input  logic [net_pkg::cord_width-1:0]          net_in_src_x_i
   , input  logic [net_pkg::cord_width-1:0]          net_in_src_y_i
   , output logic                                    net_in_ready_o
   , output logic                                    net_in_ack_o
   );

  localparam int credit_width_lp = $clog2(credits_p + 1);
  localparam int addr_w_lp       = bridge_pkg::dev_addr_width;

  logic [addr_w_lp-1:0]                 fifo_addr;
  logic [fill_width_p-1:0]              fifo_data;
  logic                                 fifo_v, fifo_yumi;
  logic                                 send_v, send_ready;
  net_pkg::host_packet_u                send_packet;
  logic [credit_width_lp-1:0]           credits_used;
  logic                                 rsp_v, rsp_yumi, req_ready;
  logic [net_pkg::data_width-1:0]       rsp_data;
  logic [net_pkg::reg_id_width-1:0]     rsp_reg_id;
  logic [7:0]                           rsp_op;

  // Lets a second access in while the first waits for its reply
  two_slot_fifo #(.width_p(fill_width_p + addr_w_lp)) fwd_fifo
    (.clk_i(clk_i), .reset_i(reset_i)
     , .data_i({fwd_data_i, fwd_addr_i}), .v_i(fwd_v_i), .ready_o(fwd_ready_o)
     , .data_o({fifo_data, fifo_addr}), .v_o(fifo_v), .yumi_i(fifo_yumi)
     );

  mmio_fifo_bridge #(.fill_width_p(fill_width_p), .credits_p(credits_p)) bridge
    (.clk_i(clk_i), .reset_i(reset_i)
     , .global_x_i(global_x_i), .global_y_i(global_y_i)
     , .fifo_addr_i(fifo_addr), .fifo_data_i(fifo_data), .fifo_v_i(fifo_v)
     , .fifo_yumi_o(fifo_yumi)
     , .rev_data_o(rev_data_o), .rev_v_o(rev_v_o), .rev_ready_i(rev_ready_i)
     , .send_v_o(send_v), .send_packet_o(send_packet)
     , .send_ready_i(send_ready), .credits_used_i(credits_used)
     , .rsp_v_i(rsp_v), .rsp_data_i(rsp_data), .rsp_reg_id_i(rsp_reg_id)
     , .rsp_op_i(rsp_op), .rsp_yumi_o(rsp_yumi)
     , .net_in_v_i(net_in_v_i), .net_in_addr_i(net_in_addr_i)
     , .net_in_data_i(net_in_data_i), .net_in_mask_i(net_in_mask_i)
     , .net_in_we_i(net_in_we_i), .net_in_src_x_i(net_in_src_x_i)
     , .net_in_src_y_i(net_in_src_y_i), .req_ready_o(req_ready)
     );

  net_endpoint #(.credits_p(credits_p)) endpoint
    (.clk_i(clk_i), .reset_i(reset_i)
     , .send_v_i(send_v), .send_packet_i(send_packet)
     , .send_ready_o(send_ready), .credits_used_o(credits_used)
     , .net_out_v_o(net_out_v_o), .net_out_packet_o(net_out_packet_o)
     , .net_credit_i(net_credit_i)
     , .net_rsp_v_i(net_rsp_v_i), .net_rsp_data_i(net_rsp_data_i)
     , .net_rsp_reg_id_i(net_rsp_reg_id_i), .net_rsp_op_i(net_rsp_op_i)
     , .rsp_v_o(rsp_v), .rsp_data_o(rsp_data), .rsp_reg_id_o(rsp_reg_id)
     , .rsp_op_o(rsp_op), .rsp_yumi_i(rsp_yumi)
     , .net_in_v_i(net_in_v_i), .net_in_ready_o(net_in_ready_o)
     , .net_in_ack_o(net_in_ack_o), .req_ready_i(req_ready)
     );

endmodule

`default_nettype wire

/* tb/tb_host_net.sv */
`default_nettype none

module tb_host_net;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int fill_width_p = 32;
  localparam int credits_p    = 8;
  // Host accesses issued by the sequence in the main process
  localparam int n_accesses      = 5 + 4 + 4 * (credits_p + 1) + 4 + 2 * 6 + 2 * 6;
  localparam int watchdog_cycles = n_accesses * 40 + 2000;
  localparam logic [31:0] seed   = 32'h115e9942;

  logic                  clk_i;
  logic                  reset_i;
  logic [7:0]            global_x_i;
  logic [7:0]            global_y_i;
  logic [19:0]           fwd_addr_i;
  logic [31:0]           fwd_data_i;
  logic                  fwd_v_i;
  logic                  fwd_ready_o;
  logic [31:0]           rev_data_o;
  logic                  rev_v_o;
  logic                  rev_ready_i;
  logic                  net_out_v_o;
  net_pkg::host_packet_u net_out_packet_o;
  logic                  net_credit_i;
  logic                  net_rsp_v_i;
  logic [31:0]           net_rsp_data_i;
  logic [7:0]            net_rsp_reg_id_i;
  logic [7:0]            net_rsp_op_i;
  logic                  net_in_v_i;
  logic [31:0]           net_in_addr_i;
  logic [31:0]           net_in_data_i;
  logic [3:0]            net_in_mask_i;
  logic                  net_in_we_i;
  logic [7:0]            net_in_src_x_i;
  logic [7:0]            net_in_src_y_i;
  logic                  net_in_ready_o;
  logic                  net_in_ack_o;

  // Reference queues and their heads as seen by the assertions
  logic [31:0]  rev_exp_q[$];
  logic [127:0] out_exp_q[$];
  logic [31:0]  rev_exp_head;
  logic         rev_pending;
  logic [127:0] out_exp_head;
  logic         out_pending;
  int           sent_count = 0;
  int           returned_count = 0;
  int           flight_snap;
  logic [31:0]  data_state;
  logic [31:0]  ready_state;

  host_net_top #(.fill_width_p(fill_width_p), .credits_p(credits_p)) DUT
    (.clk_i(clk_i), .reset_i(reset_i)
     , .global_x_i(global_x_i), .global_y_i(global_y_i)
     , .fwd_addr_i(fwd_addr_i), .fwd_data_i(fwd_data_i), .fwd_v_i(fwd_v_i)
     , .fwd_ready_o(fwd_ready_o)
     , .rev_data_o(rev_data_o), .rev_v_o(rev_v_o), .rev_ready_i(rev_ready_i)
     , .net_out_v_o(net_out_v_o), .net_out_packet_o(net_out_packet_o)
     , .net_credit_i(net_credit_i)
     , .net_rsp_v_i(net_rsp_v_i), .net_rsp_data_i(net_rsp_data_i)
     , .net_rsp_reg_id_i(net_rsp_reg_id_i), .net_rsp_op_i(net_rsp_op_i)
     , .net_in_v_i(net_in_v_i), .net_in_addr_i(net_in_addr_i)
     , .net_in_data_i(net_in_data_i), .net_in_mask_i(net_in_mask_i)
     , .net_in_we_i(net_in_we_i), .net_in_src_x_i(net_in_src_x_i)
     , .net_in_src_y_i(net_in_src_y_i), .net_in_ready_o(net_in_ready_o)
     , .net_in_ack_o(net_in_ack_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    data_state = xorshift32(data_state);
    return data_state;
  endfunction

  function automatic int in_flight();
    return sent_count - returned_count;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Queue one access and wait only for the forward transfer
  task automatic host_access(input logic [19:0] addr, input logic [31:0] data,
                             input logic [31:0] exp_data);
    rev_exp_q.push_back(exp_data);
    fwd_addr_i = addr;
    fwd_data_i = data;
    fwd_v_i    = 1'b1;
    while (!fwd_ready_o)
      next_cycle();
    next_cycle();
    fwd_v_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (rev_exp_q.size() != 0)
      next_cycle();
  endtask

  task automatic send_packet();
    logic [127:0] pkt;
    for (int k = 0; k < 4; k++)
      pkt[32*k +: 32] = next_rand();
    out_exp_q.push_back(pkt);
    for (int k = 0; k < 4; k++)
      host_access(bridge_pkg::req_fifo_addr, pkt[32*k +: 32], 32'h0);
  endtask

  task automatic return_credits(input int n);
    for (int i = 0; i < n; i++)
    begin
      net_credit_i = 1'b1;
      next_cycle();
    end
    net_credit_i = 1'b0;
  endtask

  // Drain one packet through a word FIFO, probing its entries flag
  task automatic read_packet(input logic [19:0] fifo_addr, input logic [19:0] entries_addr,
                             input logic [127:0] pkt);
    host_access(fifo_addr, 32'h0, pkt[31:0]);
    host_access(entries_addr, 32'h0, 32'h1);
    for (int k = 1; k < 4; k++)
      host_access(fifo_addr, 32'h0, pkt[32*k +: 32]);
    host_access(entries_addr, 32'h0, 32'h0);
    wait_idle();
  endtask

  task automatic net_response(input logic [7:0] reg_id, input logic [7:0] op);
    logic [31:0]  data;
    logic [127:0] pkt;
    data = next_rand();
    // Response view, always stamped with local coordinates and the response opcode
    pkt = {56'h0, 8'h02, data, 8'h00, reg_id, global_y_i, global_x_i};
    net_rsp_data_i   = data;
    net_rsp_reg_id_i = reg_id;
    net_rsp_op_i     = op;
    net_rsp_v_i      = 1'b1;
    next_cycle();
    net_rsp_v_i = 1'b0;
    read_packet(bridge_pkg::resp_fifo_addr, bridge_pkg::resp_entries_addr, pkt);
  endtask

  task automatic net_request(input logic we);
    logic [31:0]  rnd;
    logic [127:0] pkt;
    net_in_addr_i  = next_rand();
    net_in_data_i  = next_rand();
    rnd            = next_rand();
    net_in_mask_i  = rnd[3:0];
    net_in_src_x_i = rnd[15:8];
    net_in_src_y_i = rnd[23:16];
    net_in_we_i    = we;
    // Request view, mask lands in reg_id
    pkt = {16'h0, net_in_addr_i, (we ? 8'h01 : 8'h00), {4'h0, net_in_mask_i},
           net_in_data_i, net_in_src_y_i, net_in_src_x_i, global_y_i, global_x_i};
    net_in_v_i = 1'b1;
    while (!net_in_ready_o)
      next_cycle();
    next_cycle();
    net_in_v_i = 1'b0;
    assert (net_in_ready_o === 1'b0)
      else fail_run("net_in_ready_o still high with a network request held");
    read_packet(bridge_pkg::net_req_fifo_addr, bridge_pkg::net_req_entries_addr, pkt);
  endtask

  ////////////////////
  // Scoreboard upkeep
  ////////////////////
  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (rev_v_o && rev_ready_i && rev_exp_q.size() != 0)
        void'(rev_exp_q.pop_front());
      if (net_out_v_o)
      begin
        sent_count++;
        if (out_exp_q.size() != 0)
          void'(out_exp_q.pop_front());
      end
      if (net_credit_i)
        returned_count++;
    end
  end

  // Heads settle mid-cycle, clear of both edges
  always @(negedge clk_i)
  begin
    rev_pending  = (rev_exp_q.size() != 0);
    rev_exp_head = rev_pending ? rev_exp_q[0] : 32'h0;
    out_pending  = (out_exp_q.size() != 0);
    out_exp_head = out_pending ? out_exp_q[0] : 128'h0;
    flight_snap  = in_flight();
  end

  // Random stalls on the reverse port
  initial
  begin
    rev_ready_i = 1'b0;
    ready_state = ~seed;
    forever
    begin
      next_cycle();
      ready_state = xorshift32(ready_state);
      rev_ready_i = (ready_state[1:0] != 2'b00);
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  a_rev_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_o && rev_ready_i |-> rev_pending)
    else fail_run("Reverse reply retired with no host access outstanding");

  a_rev_data: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_o && rev_ready_i |-> rev_data_o == rev_exp_head)
    else fail_run($sformatf("Mismatch rev_data_o: got %h expected %h",
                            $sampled(rev_data_o), $sampled(rev_exp_head)));

  a_rev_hold_v: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_o && !rev_ready_i |=> rev_v_o)
    else fail_run("rev_v_o dropped while the host was stalling the reply");

  a_rev_hold_data: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_o && !rev_ready_i |=> rev_data_o == $past(rev_data_o))
    else fail_run($sformatf("Mismatch rev_data_o: got %h expected %h while stalled",
                            $sampled(rev_data_o), $past(rev_data_o)));

  a_out_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    net_out_v_o |-> out_pending)
    else fail_run("Network packet sent with no host packet outstanding");

  a_out_packet: assert property (@(posedge clk_i) disable iff (reset_i)
    net_out_v_o |-> net_out_packet_o == out_exp_head)
    else fail_run($sformatf("Mismatch net_out_packet_o: got %h expected %h",
                            $sampled(net_out_packet_o), $sampled(out_exp_head)));

  a_out_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    net_out_v_o |=> !net_out_v_o)
    else fail_run("net_out_v_o stayed high for more than one cycle");

  a_out_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    net_out_v_o |-> flight_snap < credits_p)
    else fail_run("Packet sent with every credit in use");

  a_ack_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    net_in_v_i && net_in_ready_o |=> net_in_ack_o)
    else fail_run("net_in_ack_o missing one cycle after an accepted request");

  a_ack_only_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    !(net_in_v_i && net_in_ready_o) |=> !net_in_ack_o)
    else fail_run("net_in_ack_o pulsed without an accepted request");

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk_i);
    fail_run("Watchdog expired before the test sequence finished");
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    reset_i          = 1'b1;
    global_x_i       = 8'h03;
    global_y_i       = 8'h05;
    fwd_addr_i       = '0;
    fwd_data_i       = '0;
    fwd_v_i          = 1'b0;
    net_credit_i     = 1'b0;
    net_rsp_v_i      = 1'b0;
    net_rsp_data_i   = '0;
    net_rsp_reg_id_i = '0;
    net_rsp_op_i     = '0;
    net_in_v_i       = 1'b0;
    net_in_addr_i    = '0;
    net_in_data_i    = '0;
    net_in_mask_i    = '0;
    net_in_we_i      = 1'b0;
    net_in_src_x_i   = '0;
    net_in_src_y_i   = '0;
    data_state       = seed;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    assert (rev_v_o === 1'b0 && net_out_v_o === 1'b0 && net_in_ack_o === 1'b0)
      else fail_run("Outputs rev_v_o, net_out_v_o or net_in_ack_o high after reset");
    assert (fwd_ready_o === 1'b1 && net_in_ready_o === 1'b1)
      else fail_run("Forward port or network request port not ready after reset");

    // Empty flags, zero credits and unmapped addresses
    host_access(bridge_pkg::resp_entries_addr, 32'h0, 32'h0);
    host_access(bridge_pkg::net_req_entries_addr, 32'h0, 32'h0);
    host_access(bridge_pkg::req_credits_addr, 32'h0, 32'h0);
    host_access(20'h0_0700, 32'h0, 32'h0);
    host_access(20'h0_0704, next_rand(), 32'h0);
    wait_idle();

    // Single packet out, then its credit comes back
    send_packet();
    wait_idle();
    while (out_exp_q.size() != 0)
      next_cycle();
    return_credits(1);
    host_access(bridge_pkg::req_credits_addr, 32'h0, 32'(in_flight()));
    wait_idle();

    // One packet more than the credits allow
    repeat (credits_p + 1) send_packet();
    wait_idle();
    while (in_flight() != credits_p)
      next_cycle();
    repeat (20) next_cycle();
    assert (in_flight() == credits_p && out_exp_q.size() == 1)
      else fail_run("Last packet did not wait for a credit");
    host_access(bridge_pkg::req_credits_addr, 32'h0, 32'(in_flight()));
    wait_idle();
    return_credits(1);
    while (out_exp_q.size() != 0)
      next_cycle();
    host_access(bridge_pkg::req_credits_addr, 32'h0, 32'(in_flight()));
    wait_idle();
    return_credits(credits_p);
    host_access(bridge_pkg::req_credits_addr, 32'h0, 32'(in_flight()));
    wait_idle();

    net_response(8'h11, 8'h07);
    net_response(8'h2a, 8'h02);

    net_request(1'b1);
    net_request(1'b0);

    repeat (4) next_cycle();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
design/bridge_pkg.sv
design/net_pkg.sv
design/two_slot_fifo.sv
design/word_sipo.sv
design/word_piso.sv
design/net_endpoint.sv
design/mmio_fifo_bridge.sv
design/host_net_top.sv
tb/tb_host_net.sv

/* Bender.yml */
package:
  name: host_net_bridge

sources:
  - design/bridge_pkg.sv
  - design/net_pkg.sv
  - design/two_slot_fifo.sv
  - design/word_sipo.sv
  - design/word_piso.sv
  - design/net_endpoint.sv
  - design/mmio_fifo_bridge.sv
  - design/host_net_top.sv
  - target: test
    files:
      - tb/tb_host_net.sv
